// ==== design/dbg_wb_pkg.sv ====
package dbg_wb_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int DBG_ADDR_W = 32;
  localparam int DBG_DATA_W = 32;
  localparam int DBG_SEL_W  = 4;

  // Word size codes from the debug side
  // Anything else is handled as a full word
  localparam logic [3:0] DBG_SIZE_BYTE = 4'd1;
  localparam logic [3:0] DBG_SIZE_HALF = 4'd2;
  localparam logic [3:0] DBG_SIZE_WORD = 4'd4;

  //////////////////////////////
  // Configuration window
  //////////////////////////////

  // Top address byte selecting the local registers
  localparam logic [7:0] DBG_CFG_PAGE = 8'hFF;

  // Register offsets inside the window
  localparam logic [DBG_ADDR_W-9:0] DBG_CFG_ENDIAN_OFS = 'd0;
  localparam logic [DBG_ADDR_W-9:0] DBG_CFG_TMO_OFS    = 'd4;

  // Ack timeout, counted in Wishbone cycles
  localparam int DBG_TMO_W = 8;

  // Little endian out of reset
  localparam logic                 DBG_ENDIAN_RST = 1'b1;
  localparam logic [DBG_TMO_W-1:0] DBG_TMO_RST    = 8'd16;

endpackage

// ==== design/dbg_toggle_sync.sv ====
`timescale 1ns/100ps

module dbg_toggle_sync (
  input  logic clk_i,
  input  logic rst_i,
  input  logic tgl_i,
  output logic pls_o
);

  // Two sync stages, then one stage kept for edge detect
  logic sync1;
  logic sync2;
  logic sync2_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sync1   <= 1'b0;
      sync2   <= 1'b0;
      sync2_q <= 1'b0;
    end else begin
      sync1   <= tgl_i;
      sync2   <= sync1;
      sync2_q <= sync2;
    end
  end

  // Any level change on the source side gives one pulse here
  assign pls_o = sync2 ^ sync2_q;

endmodule

// ==== design/dbg_lane_steer.sv ====
`timescale 1ns/100ps

module dbg_lane_steer
  import dbg_wb_pkg::*;
(
  input  logic                  little_i,
  input  logic [           1:0] addr_lo_i,
  input  logic [           3:0] word_size_i,
  input  logic [DBG_DATA_W-1:0] wdat_i,
  input  logic [ DBG_SEL_W-1:0] rsel_i,
  input  logic [DBG_DATA_W-1:0] rdat_i,
  output logic [ DBG_SEL_W-1:0] sel_o,
  output logic [DBG_DATA_W-1:0] wdat_o,
  output logic [DBG_DATA_W-1:0] rdat_o
);

  //////////////////////////////
  // Byte select decode
  //////////////////////////////

  // Byte k sits on lane k (little) or lane 3-k (big)
  always_comb begin
    case (word_size_i)
      DBG_SIZE_BYTE: begin
        sel_o = little_i ? (4'b0001 << addr_lo_i) : (4'b1000 >> addr_lo_i);
      end
      DBG_SIZE_HALF: begin
        if (addr_lo_i[1] ^ ~little_i) begin
          sel_o = 4'b1100;
        end else begin
          sel_o = 4'b0011;
        end
      end
      // Words and unknown sizes use every lane
      default: sel_o = 4'b1111;
    endcase
  end

  //////////////////////////////
  // Write path
  //////////////////////////////

  // Short data comes in left aligned
  always_comb begin
    case (sel_o)
      4'b0011: wdat_o = {16'h0, wdat_i[31:16]};
      4'b1100: wdat_o = {wdat_i[31:16], 16'h0};
      4'b0001: wdat_o = {24'h0, wdat_i[31:24]};
      4'b0010: wdat_o = {16'h0, wdat_i[31:24], 8'h0};
      4'b0100: wdat_o = {8'h0, wdat_i[31:24], 16'h0};
      4'b1000: wdat_o = {wdat_i[31:24], 24'h0};
      default: wdat_o = wdat_i;
    endcase
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  // Selected lanes go down to bit 0, the rest cleared
  always_comb begin
    case (rsel_i)
      4'b0011: rdat_o = {16'h0, rdat_i[15:0]};
      4'b1100: rdat_o = {16'h0, rdat_i[31:16]};
      4'b0001: rdat_o = {24'h0, rdat_i[7:0]};
      4'b0010: rdat_o = {24'h0, rdat_i[15:8]};
      4'b0100: rdat_o = {24'h0, rdat_i[23:16]};
      4'b1000: rdat_o = {24'h0, rdat_i[31:24]};
      default: rdat_o = rdat_i;
    endcase
  end

endmodule

// ==== design/dbg_bus_cfg.sv ====
`timescale 1ns/100ps

module dbg_bus_cfg
  import dbg_wb_pkg::*;
(
  input  logic                  biu_clk_i,
  input  logic                  rst_i,
  input  logic                  wr_i,
  input  logic [DBG_ADDR_W-9:0] ofs_i,
  input  logic [DBG_DATA_W-1:0] wdat_i,
  output logic                  little_o,
  output logic [ DBG_TMO_W-1:0] tmo_o,
  output logic [DBG_DATA_W-1:0] rdat_o
);

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge biu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      little_o <= DBG_ENDIAN_RST;
      tmo_o    <= DBG_TMO_RST;
    end else if (wr_i) begin
      case (ofs_i)
        DBG_CFG_ENDIAN_OFS: little_o <= wdat_i[0];
        DBG_CFG_TMO_OFS:    tmo_o    <= wdat_i[DBG_TMO_W-1:0];
        // Writes elsewhere in the window are dropped
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Read back
  //////////////////////////////

  always_comb begin
    rdat_o = '0;
    case (ofs_i)
      DBG_CFG_ENDIAN_OFS: rdat_o[0] = little_o;
      DBG_CFG_TMO_OFS:    rdat_o[DBG_TMO_W-1:0] = tmo_o;
      default: ;
    endcase
  end

endmodule

// ==== design/dbg_biu_port.sv ====
`timescale 1ns/100ps

module dbg_biu_port
  import dbg_wb_pkg::*;
(
  input  logic                  biu_clk_i,
  input  logic                  wb_rst,
  input  logic                  biu_strb_i,
  input  logic                  biu_rw_i,
  input  logic [DBG_ADDR_W-1:0] biu_addr_i,
  input  logic [DBG_DATA_W-1:0] biu_di_i,
  input  logic [           3:0] biu_word_size_i,
  output logic                  biu_rdy_o,
  output logic [DBG_DATA_W-1:0] biu_do_o,
  output logic                  biu_err_o,
  input  logic                  done_pls_i,
  input  logic [DBG_DATA_W-1:0] wb_rdat_i,
  input  logic                  wb_err_i,
  output logic                  cmd_tgl_o,
  output logic [DBG_ADDR_W-1:0] adr_o,
  output logic [ DBG_SEL_W-1:0] sel_o,
  output logic [DBG_DATA_W-1:0] wdat_o,
  output logic                  we_o,
  output logic                  little_o,
  output logic [ DBG_TMO_W-1:0] tmo_o
);

  logic [           1:0] rst_sync;
  logic                  rst;
  logic                  accept;
  logic                  is_cfg;
  logic                  cfg_pend;
  logic                  tgt_cfg;
  logic [ DBG_SEL_W-1:0] sel_dec;
  logic [DBG_DATA_W-1:0] wdat_steer;
  logic [DBG_DATA_W-1:0] cfg_rdat;
  logic [DBG_DATA_W-1:0] cfg_rdat_q;

  // Reset release synchronized to the debug clock
  always_ff @(posedge biu_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      rst_sync <= 2'b11;
    end else begin
      rst_sync <= {1'b0, rst_sync[1]};
    end
  end

  assign rst = rst_sync[0];

  //////////////////////////////
  // Command decode
  //////////////////////////////

  assign accept = biu_strb_i & biu_rdy_o;
  assign is_cfg = (biu_addr_i[DBG_ADDR_W-1 -: 8] == DBG_CFG_PAGE);

  dbg_bus_cfg u_cfg (
    .biu_clk_i(biu_clk_i),
    .rst_i    (rst),
    .wr_i     (accept & is_cfg & ~biu_rw_i),
    .ofs_i    (biu_addr_i[DBG_ADDR_W-9:0]),
    .wdat_i   (biu_di_i),
    .little_o (little_o),
    .tmo_o    (tmo_o),
    .rdat_o   (cfg_rdat)
  );

  // Only the write half is used on this side
  dbg_lane_steer u_wr_steer (
    .little_i   (little_o),
    .addr_lo_i  (biu_addr_i[1:0]),
    .word_size_i(biu_word_size_i),
    .wdat_i     (biu_di_i),
    .rsel_i     ('0),
    .rdat_i     ('0),
    .sel_o      (sel_dec),
    .wdat_o     (wdat_steer),
    .rdat_o     ()
  );

  //////////////////////////////
  // Command latch
  //////////////////////////////

  // Held steady while the Wishbone side reads them
  always_ff @(posedge biu_clk_i) begin
    if (accept && !is_cfg) begin
      adr_o  <= biu_addr_i;
      sel_o  <= sel_dec;
      wdat_o <= wdat_steer;
      we_o   <= ~biu_rw_i;
    end
  end

  always_ff @(posedge biu_clk_i) begin
    if (accept && is_cfg && biu_rw_i) begin
      cfg_rdat_q <= cfg_rdat;
    end
  end

  //////////////////////////////
  // Handshake
  //////////////////////////////

  always_ff @(posedge biu_clk_i or posedge rst) begin
    if (rst) begin
      biu_rdy_o <= 1'b1;
      cmd_tgl_o <= 1'b0;
      cfg_pend  <= 1'b0;
      tgt_cfg   <= 1'b0;
    end else begin
      cfg_pend <= accept & is_cfg;
      if (accept) begin
        biu_rdy_o <= 1'b0;
        tgt_cfg   <= is_cfg;
        // Bus commands go across as a level change
        if (!is_cfg) begin
          cmd_tgl_o <= ~cmd_tgl_o;
        end
      end else if (cfg_pend || done_pls_i) begin
        biu_rdy_o <= 1'b1;
      end
    end
  end

  // Local window never reports an error
  assign biu_do_o  = tgt_cfg ? cfg_rdat_q : wb_rdat_i;
  assign biu_err_o = tgt_cfg ? 1'b0 : wb_err_i;

  // Bus command fields are crossed raw, so they may not move in flight
  a_cmd_stable : assert property (@(posedge biu_clk_i) disable iff (rst)
    !biu_rdy_o |=> $stable(adr_o) && $stable(sel_o) && $stable(wdat_o) && $stable(we_o));

  // Completion from the Wishbone side only while a command is outstanding
  a_done_busy : assert property (@(posedge biu_clk_i) disable iff (rst)
    done_pls_i |-> !biu_rdy_o);

endmodule

// ==== design/dbg_wb_master.sv ====
`timescale 1ns/100ps

module dbg_wb_master
  import dbg_wb_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  wb_rst,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [DBG_ADDR_W-1:0] wb_adr_o,
  output logic [ DBG_SEL_W-1:0] wb_sel_o,
  output logic [DBG_DATA_W-1:0] wb_dat_o,
  input  logic [DBG_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i,
  input  logic                  start_pls_i,
  input  logic [DBG_ADDR_W-1:0] adr_i,
  input  logic [ DBG_SEL_W-1:0] sel_i,
  input  logic [DBG_DATA_W-1:0] wdat_i,
  input  logic                  we_i,
  input  logic [ DBG_TMO_W-1:0] tmo_i,
  input  logic                  little_i,
  output logic                  done_tgl_o,
  output logic [DBG_DATA_W-1:0] rdat_o,
  output logic                  err_o
);

  typedef enum logic {
    ST_IDLE,
    ST_XFER
  } wb_state_t;

  logic [           1:0] rst_sync;
  logic                  rst;
  wb_state_t             state;
  logic [ DBG_TMO_W-1:0] tmo_cnt;
  logic                  tmo_hit;
  logic                  resp;
  logic                  done;
  logic [DBG_DATA_W-1:0] rdat_steer;

  // Reset release synchronized to the Wishbone clock
  always_ff @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      rst_sync <= 2'b11;
    end else begin
      rst_sync <= {1'b0, rst_sync[1]};
    end
  end

  assign rst = rst_sync[0];

  // Quasi-static fields from the debug side
  assign wb_adr_o = adr_i;
  assign wb_sel_o = sel_i;
  assign wb_dat_o = wdat_i;
  assign wb_we_o  = we_i;

  // Read half only, selects come from the latched command
  dbg_lane_steer u_rd_steer (
    .little_i   (little_i),
    .addr_lo_i  (2'b00),
    .word_size_i(DBG_SIZE_WORD),
    .wdat_i     ('0),
    .rsel_i     (sel_i),
    .rdat_i     (wb_dat_i),
    .sel_o      (),
    .wdat_o     (),
    .rdat_o     (rdat_steer)
  );

  //////////////////////////////
  // Cycle control
  //////////////////////////////

  assign resp    = wb_ack_i | wb_err_i;
  assign tmo_hit = (tmo_cnt == tmo_i);
  assign done    = (state == ST_XFER) & (resp | tmo_hit);

  always_ff @(posedge wb_clk_i or posedge rst) begin
    if (rst) begin
      state      <= ST_IDLE;
      wb_cyc_o   <= 1'b0;
      wb_stb_o   <= 1'b0;
      tmo_cnt    <= '0;
      err_o      <= 1'b0;
      done_tgl_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_pls_i) begin
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
            tmo_cnt  <= '0;
            state    <= ST_XFER;
          end
        end
        ST_XFER: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (done) begin
            wb_cyc_o   <= 1'b0;
            wb_stb_o   <= 1'b0;
            // Ack on the last counted cycle still wins
            err_o      <= wb_err_i | (tmo_hit & ~wb_ack_i);
            done_tgl_o <= ~done_tgl_o;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Read data capture at the end of the cycle
  always_ff @(posedge wb_clk_i) begin
    if (done) begin
      rdat_o <= rdat_steer;
    end
  end

  a_stb_in_cyc : assert property (@(posedge wb_clk_i) disable iff (rst)
    wb_stb_o |-> wb_cyc_o);

  // Debug side must wait for completion before the next start
  a_start_idle : assert property (@(posedge wb_clk_i) disable iff (rst)
    start_pls_i |-> state == ST_IDLE);

endmodule

// ==== design/dbg_wb_bridge.sv ====
`timescale 1ns/100ps

module dbg_wb_bridge
  import dbg_wb_pkg::*;
(
  input  logic                  wb_rst,
  // Debug domain
  input  logic                  biu_clk_i,
  input  logic                  biu_strb_i,
  input  logic                  biu_rw_i,
  input  logic [DBG_ADDR_W-1:0] biu_addr_i,
  input  logic [DBG_DATA_W-1:0] biu_di_i,
  input  logic [           3:0] biu_word_size_i,
  output logic                  biu_rdy_o,
  output logic [DBG_DATA_W-1:0] biu_do_o,
  output logic                  biu_err_o,
  // Wishbone domain
  input  logic                  wb_clk_i,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [DBG_ADDR_W-1:0] wb_adr_o,
  output logic [ DBG_SEL_W-1:0] wb_sel_o,
  output logic [DBG_DATA_W-1:0] wb_dat_o,
  input  logic [DBG_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i
);

  logic                  cmd_tgl;
  logic                  start_pls;
  logic                  done_tgl;
  logic                  done_pls;
  logic [DBG_ADDR_W-1:0] cmd_adr;
  logic [ DBG_SEL_W-1:0] cmd_sel;
  logic [DBG_DATA_W-1:0] cmd_wdat;
  logic                  cmd_we;
  logic [ DBG_TMO_W-1:0] tmo;
  logic                  little;
  logic [DBG_DATA_W-1:0] rsp_rdat;
  logic                  rsp_err;

  //////////////////////////////
  // Debug side
  //////////////////////////////

  dbg_biu_port u_biu (
    .biu_clk_i      (biu_clk_i),
    .wb_rst         (wb_rst),
    .biu_strb_i     (biu_strb_i),
    .biu_rw_i       (biu_rw_i),
    .biu_addr_i     (biu_addr_i),
    .biu_di_i       (biu_di_i),
    .biu_word_size_i(biu_word_size_i),
    .biu_rdy_o      (biu_rdy_o),
    .biu_do_o       (biu_do_o),
    .biu_err_o      (biu_err_o),
    .done_pls_i     (done_pls),
    .wb_rdat_i      (rsp_rdat),
    .wb_err_i       (rsp_err),
    .cmd_tgl_o      (cmd_tgl),
    .adr_o          (cmd_adr),
    .sel_o          (cmd_sel),
    .wdat_o         (cmd_wdat),
    .we_o           (cmd_we),
    .little_o       (little),
    .tmo_o          (tmo)
  );

  // Command start into the Wishbone clock
  dbg_toggle_sync u_start_sync (
    .clk_i(wb_clk_i),
    .rst_i(wb_rst),
    .tgl_i(cmd_tgl),
    .pls_o(start_pls)
  );

  // Completion back into the debug clock
  dbg_toggle_sync u_done_sync (
    .clk_i(biu_clk_i),
    .rst_i(wb_rst),
    .tgl_i(done_tgl),
    .pls_o(done_pls)
  );

  //////////////////////////////
  // Wishbone side
  //////////////////////////////

  dbg_wb_master u_wbm (
    .wb_clk_i   (wb_clk_i),
    .wb_rst     (wb_rst),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_we_o    (wb_we_o),
    .wb_adr_o   (wb_adr_o),
    .wb_sel_o   (wb_sel_o),
    .wb_dat_o   (wb_dat_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .wb_err_i   (wb_err_i),
    .start_pls_i(start_pls),
    .adr_i      (cmd_adr),
    .sel_i      (cmd_sel),
    .wdat_i     (cmd_wdat),
    .we_i       (cmd_we),
    .tmo_i      (tmo),
    .little_i   (little),
    .done_tgl_o (done_tgl),
    .rdat_o     (rsp_rdat),
    .err_o      (rsp_err)
  );

endmodule

// ==== test/tb_wb_mem_model.sv ====
`timescale 1ns/100ps

module tb_wb_mem_model (
  input  logic        wb_clk_i,
  input  logic        wb_rst,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [ 3:0] wb_sel_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o
);

  // 1 KiB backing store, indexed by word and lane
  logic [ 7:0] mem [0:1023];
  logic [31:0] rnd;
  logic        pending;
  logic [ 2:0] wait_cnt;
  logic        in_ack;
  logic        in_err;
  logic [ 9:0] base;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////
  // Address regions
  //////////////////////////////

  // Err page at 0x1000, nothing answers from 0x2000 up
  assign in_err   = (wb_adr_i[31:8] == 24'h000010);
  assign in_ack   = (wb_adr_i < 32'h2000) && !in_err;
  assign base     = {wb_adr_i[9:2], 2'b00};
  assign wb_dat_o = in_ack ? {mem[base+3], mem[base+2], mem[base+1], mem[base]} : '0;

  //////////////////////////////
  // Response
  //////////////////////////////

  always @(posedge wb_clk_i or posedge wb_rst) begin
    if (wb_rst) begin
      rnd      <= 32'h6646;
      pending  <= 1'b0;
      wait_cnt <= '0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      // Single cycle response pulses
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      if (!(wb_cyc_i && wb_stb_i)) begin
        pending <= 1'b0;
      end else if (!pending) begin
        // New cycle seen, pick 0 to 5 wait states
        pending  <= 1'b1;
        wait_cnt <= 3'(xorshift32(rnd) % 6);
        rnd      <= xorshift32(rnd);
      end else if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else if (!wb_ack_o && !wb_err_o) begin
        if (in_err) begin
          wb_err_o <= 1'b1;
        end else if (in_ack) begin
          wb_ack_o <= 1'b1;
          if (wb_we_i) begin
            for (int k = 0; k < 4; k++) begin
              if (wb_sel_i[k]) begin
                mem[base+k] <= wb_dat_i[8*k +: 8];
              end
            end
          end
        end
      end
    end
  end

endmodule

// ==== test/tb_dbg_wb_bridge.sv ====
`timescale 1ns/100ps

module tb_dbg_wb_bridge
  import dbg_wb_pkg::*;
();

  // Test lengths and run limit in Wishbone cycles
  localparam int N_WORDS       = 16;
  localparam int N_MIX         = 12;
  localparam int N_CMDS        = 2 + 2 * N_WORDS + 2 + 6 * N_MIX + 8 + 5;
  localparam int CMD_WB_CYCLES = 32;
  localparam int CYCLE_LIMIT   = 40 * N_CMDS * CMD_WB_CYCLES;

  typedef struct packed {
    logic        cfg;
    logic        chk;
    logic        err;
    logic        tmo;
    logic [31:0] data;
  } exp_t;

  logic                  wb_clk_i;
  logic                  biu_clk_i;
  logic                  wb_rst;
  logic                  biu_strb_i;
  logic                  biu_rw_i;
  logic [DBG_ADDR_W-1:0] biu_addr_i;
  logic [DBG_DATA_W-1:0] biu_di_i;
  logic [           3:0] biu_word_size_i;
  logic                  biu_rdy_o;
  logic [DBG_DATA_W-1:0] biu_do_o;
  logic                  biu_err_o;
  logic                  wb_cyc_o;
  logic                  wb_stb_o;
  logic                  wb_we_o;
  logic [DBG_ADDR_W-1:0] wb_adr_o;
  logic [ DBG_SEL_W-1:0] wb_sel_o;
  logic [DBG_DATA_W-1:0] wb_dat_o;
  logic [DBG_DATA_W-1:0] wb_dat_i;
  logic                  wb_ack_i;
  logic                  wb_err_i;

  // Expected state of memory lanes and config registers
  logic [ 7:0] shadow [0:1023];
  logic        exp_little;
  logic [ 7:0] exp_tmo;
  logic [31:0] rnd;
  logic [31:0] written_q[$];
  exp_t        exp_q[$];
  int          n_issued;
  int          n_done;
  int          n_checks;
  int          n_val_err;
  int          n_other_err;
  int          cycles;
  int          cyc_len;

  dbg_wb_bridge u_dut (.*);

  tb_wb_mem_model u_mem (
    .wb_clk_i(wb_clk_i),
    .wb_rst  (wb_rst),
    .wb_cyc_i(wb_cyc_o),
    .wb_stb_i(wb_stb_o),
    .wb_we_i (wb_we_o),
    .wb_adr_i(wb_adr_o),
    .wb_sel_i(wb_sel_o),
    .wb_dat_i(wb_dat_o),
    .wb_dat_o(wb_dat_i),
    .wb_ack_o(wb_ack_i),
    .wb_err_o(wb_err_i)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #10 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    biu_clk_i = 1'b0;
    forever #15 biu_clk_i = ~biu_clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd = xorshift32(rnd);
    return rnd;
  endfunction

  // Byte k on lane k, or lane 3-k when big endian
  function automatic int byte_lane(input logic [31:0] a);
    return exp_little ? int'(a[1:0]) : 3 - int'(a[1:0]);
  endfunction

  // Lower lane of the addressed half
  function automatic int half_lane(input logic [31:0] a);
    if (exp_little) begin
      return a[1] ? 2 : 0;
    end
    return a[1] ? 0 : 2;
  endfunction

  function automatic exp_t dbg_expect(input logic rw, input logic [31:0] a,
                                      input logic [3:0] size);
    exp_t e;
    int   base;
    int   ln;
    e    = '0;
    base = {a[9:2], 2'b00};
    if (a[31:24] == 8'hFF) begin
      // Local window, never an error
      e.cfg = 1'b1;
      e.chk = rw;
      if (a[23:0] == 24'h0) begin
        e.data = {31'h0, exp_little};
      end else if (a[23:0] == 24'h4) begin
        e.data = {24'h0, exp_tmo};
      end
    end else if (a[31:8] == 24'h000010) begin
      e.err = 1'b1;
    end else if (a >= 32'h2000) begin
      // Silent slave, ends on timeout
      e.err = 1'b1;
      e.tmo = 1'b1;
    end else if (rw) begin
      e.chk = 1'b1;
      case (size)
        DBG_SIZE_BYTE: e.data = {24'h0, shadow[base+byte_lane(a)]};
        DBG_SIZE_HALF: begin
          ln     = base + half_lane(a);
          e.data = {16'h0, shadow[ln+1], shadow[ln]};
        end
        default: e.data = {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
      endcase
    end
    return e;
  endfunction

  // Short write data is taken from the top bits
  task automatic apply_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] size);
    int base;
    int ln;
    base = {a[9:2], 2'b00};
    if (a[31:24] == 8'hFF) begin
      if (a[23:0] == 24'h0) begin
        exp_little = d[0];
      end else if (a[23:0] == 24'h4) begin
        exp_tmo = d[7:0];
      end
    end else if (a < 32'h400) begin
      case (size)
        DBG_SIZE_BYTE: shadow[base+byte_lane(a)] = d[31:24];
        DBG_SIZE_HALF: begin
          ln             = base + half_lane(a);
          shadow[ln+1]   = d[31:24];
          shadow[ln]     = d[23:16];
        end
        default: begin
          for (int k = 0; k < 4; k++) begin
            shadow[base+k] = d[8*k +: 8];
          end
        end
      endcase
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    n_checks++;
    assert (got === want) else begin
      n_val_err++;
      $display("error %0t %s got 0x%h expected 0x%h", $time, name, got, want);
    end
  endtask

  task automatic run_cmd(input logic rw, input logic [31:0] a, input logic [31:0] d,
                         input logic [3:0] size);
    exp_q.push_back(dbg_expect(rw, a, size));
    n_issued++;
    @(posedge biu_clk_i);
    #2;
    cyc_len         = 0;
    biu_strb_i      = 1'b1;
    biu_rw_i        = rw;
    biu_addr_i      = a;
    biu_di_i        = d;
    biu_word_size_i = size;
    // Ready is high here, so this edge accepts
    @(posedge biu_clk_i);
    #2;
    biu_strb_i = 1'b0;
    if (!rw) begin
      apply_write(a, d, size);
    end
    wait (n_done == n_issued);
  endtask

  // Sub-word write, same size read, then the whole word
  task automatic run_mix(input int count);
    logic [31:0] r;
    logic [31:0] a;
    logic [ 3:0] sz;
    repeat (count) begin
      r  = next_rand();
      a  = written_q[r[15:8] % written_q.size()] | r[1:0];
      sz = r[4] ? DBG_SIZE_HALF : DBG_SIZE_BYTE;
      if (r[4]) begin
        a[0] = 1'b0;
      end
      run_cmd(1'b0, a, next_rand(), sz);
      run_cmd(1'b1, a, '0, sz);
      run_cmd(1'b1, a & ~32'h3, '0, DBG_SIZE_WORD);
    end
  endtask

  initial begin : stimulus
    logic [31:0] a;
    biu_strb_i      = 1'b0;
    biu_rw_i        = 1'b0;
    biu_addr_i      = '0;
    biu_di_i        = '0;
    biu_word_size_i = DBG_SIZE_WORD;
    wb_rst          = 1'b1;
    rnd             = 32'h6646;
    exp_little      = 1'b1;
    exp_tmo         = 8'd16;
    cyc_len         = 0;
    repeat (2) @(posedge wb_clk_i);
    #2;
    wb_rst = 1'b0;
    repeat (4) @(posedge biu_clk_i);
    @(negedge biu_clk_i);
    check_val("biu_rdy_o", biu_rdy_o, 1);
    check_val("biu_err_o", biu_err_o, 0);
    check_val("wb_cyc_o", wb_cyc_o, 0);
    check_val("wb_stb_o", wb_stb_o, 0);
    // Config registers at their reset values
    run_cmd(1'b1, 32'hFF00_0000, '0, DBG_SIZE_WORD);
    run_cmd(1'b1, 32'hFF00_0004, '0, DBG_SIZE_WORD);
    // Random words through the ack region
    for (int i = 0; i < N_WORDS; i++) begin
      a = next_rand() & 32'h0000_03FC;
      written_q.push_back(a);
      run_cmd(1'b0, a, next_rand(), DBG_SIZE_WORD);
    end
    foreach (written_q[j]) begin
      run_cmd(1'b1, written_q[j], '0, DBG_SIZE_WORD);
    end
    run_mix(N_MIX);
    // Switch to big endian and repeat the mix
    run_cmd(1'b0, 32'hFF00_0000, '0, DBG_SIZE_WORD);
    run_cmd(1'b1, 32'hFF00_0000, '0, DBG_SIZE_WORD);
    run_mix(N_MIX);
    // Err page, each followed by a good read
    for (int i = 0; i < 4; i++) begin
      a = 32'h0000_1000 | (next_rand() & 32'h0000_00FC);
      run_cmd(i[0], a, next_rand(), DBG_SIZE_WORD);
      run_cmd(1'b1, written_q[i], '0, DBG_SIZE_WORD);
    end
    // Silent region, then again with a shorter timeout
    // Still above the slowest ack of the memory model
    run_cmd(1'b1, 32'h0000_2000 | (next_rand() & 32'h0000_0FFC), '0, DBG_SIZE_WORD);
    run_cmd(1'b0, 32'hFF00_0004, 32'd8, DBG_SIZE_WORD);
    run_cmd(1'b1, 32'hFF00_0004, '0, DBG_SIZE_WORD);
    run_cmd(1'b0, 32'h0000_3000, next_rand(), DBG_SIZE_WORD);
    run_cmd(1'b1, written_q[0], '0, DBG_SIZE_WORD);
    repeat (4) @(posedge biu_clk_i);
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, n_val_err, n_other_err);
    if (n_val_err == 0 && n_other_err == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  //////////////////////////////
  // Response checking
  //////////////////////////////

  // Wishbone cycles with cyc high for the current command
  initial begin : measure
    forever begin
      @(negedge wb_clk_i);
      if (wb_cyc_o) begin
        cyc_len++;
      end
    end
  end

  // Sampled at the falling debug edge, away from updates
  initial begin : compare
    exp_t e;
    logic rdy_q;
    int   low_cycles;
    rdy_q      = 1'b1;
    low_cycles = 0;
    n_done     = 0;
    forever begin
      @(negedge biu_clk_i);
      if (!biu_rdy_o) begin
        low_cycles++;
      end else if (!rdy_q) begin
        if (exp_q.size() == 0) begin
          n_other_err++;
          $display("Ready rose at %0t with no command outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          check_val("biu_err_o", biu_err_o, e.err);
          check_val("wb_cyc_o", wb_cyc_o, 0);
          check_val("wb_stb_o", wb_stb_o, 0);
          if (e.chk) begin
            check_val("biu_do_o", biu_do_o, e.data);
          end
          if (e.cfg) begin
            assert (low_cycles == 1) else begin
              n_other_err++;
              $display("Config access at %0t held ready low for %0d cycles instead of one",
                       $time, low_cycles);
            end
          end
          // Cycle length follows the programmed timeout
          if (e.tmo) begin
            assert (cyc_len >= exp_tmo && cyc_len <= exp_tmo + 2) else begin
              n_other_err++;
              $display("Wishbone cycle at %0t ran %0d cycles with a timeout of %0d",
                       $time, cyc_len, exp_tmo);
            end
          end
          n_done++;
        end
        low_cycles = 0;
      end
      rdy_q = biu_rdy_o;
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge wb_clk_i);
      cycles++;
    end
    $display("Run did not finish within %0d Wishbone cycles", CYCLE_LIMIT);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/dbg_wb_pkg.sv
design/dbg_toggle_sync.sv
design/dbg_lane_steer.sv
design/dbg_bus_cfg.sv
design/dbg_biu_port.sv
design/dbg_wb_master.sv
design/dbg_wb_bridge.sv
test/tb_wb_mem_model.sv
test/tb_dbg_wb_bridge.sv
